// File: axi_wr_demux.f
rtl/axi_wr_demux_pkg.sv
rtl/id_table_if.sv
rtl/aw_route_ctrl.sv
rtl/id_flight_table.sv
rtl/w_steer.sv
rtl/b_rr_arbiter.sv
rtl/axi_wr_demux.sv
tb/wr_demux_checker.sv
tb/tb_axi_wr_demux.sv

// File: rtl/aw_route_ctrl.sv
// AW admission with a lock flag, valid goes only to the selected port
// a decision is pushed to the table and the W queue exactly once
// aw_beat_i and aw_sel_i must hold while aw_valid_i waits

`timescale 1ns/100ps

module aw_route_ctrl #(
  parameter int unsigned NumMstPorts = axi_wr_demux_pkg::DefNumMstPorts,
  parameter int unsigned LookBits    = axi_wr_demux_pkg::DefLookBits,
  localparam int unsigned SelWidth   = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       aw_valid_i,
  input  axi_wr_demux_pkg::aw_beat_t aw_beat_i,
  input  logic [SelWidth-1:0]        aw_sel_i,
  output logic                       aw_ready_o,
  output logic [NumMstPorts-1:0]     mst_aw_valid_o,
  output axi_wr_demux_pkg::aw_beat_t mst_aw_beat_o,
  input  logic [NumMstPorts-1:0]     mst_aw_ready_i,
  input  logic                       wq_full_i,
  output logic                       wq_push_o,
  output logic [SelWidth-1:0]        wq_sel_o,
  id_table_if.ctrl                   tbl
);

  logic lock_q;
  logic lock_d;
  logic aw_valid;
  logic sel_ready;

  // table lookup and push both use the low ID bits of the offered AW
  assign tbl.lookup_id = aw_beat_i.id[LookBits-1:0];
  assign tbl.push_id   = aw_beat_i.id[LookBits-1:0];
  assign tbl.push_sel  = aw_sel_i;
  assign tbl.push      = wq_push_o;
  assign wq_sel_o      = aw_sel_i;

  // ------------------------------
  // admission
  // ------------------------------
  always_comb begin
    aw_valid  = 1'b0;
    wq_push_o = 1'b0;
    lock_d    = lock_q;
    if (lock_q) begin
      // decision already pushed, just wait for the handshake
      aw_valid = 1'b1;
      if (sel_ready) begin
        lock_d = 1'b0;
      end
    end else if (!tbl.full && !wq_full_i && aw_valid_i &&
                 (!tbl.occupied || (tbl.lookup_sel == aw_sel_i))) begin
      aw_valid  = 1'b1;
      wq_push_o = 1'b1;
      // no handshake yet, keep valid up without a second push
      if (!sel_ready) begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // fan-out of valid, ready back from the selected port only
  always_comb begin
    mst_aw_valid_o = '0;
    sel_ready      = 1'b0;
    for (int i = 0; i < int'(NumMstPorts); i++) begin
      if (aw_sel_i == SelWidth'(i)) begin
        mst_aw_valid_o[i] = aw_valid;
        sel_ready         = mst_aw_ready_i[i];
      end
    end
  end

  assign aw_ready_o    = aw_valid & sel_ready;
  assign mst_aw_beat_o = aw_beat_i;

endmodule

// File: rtl/axi_wr_demux.sv
// write half of a demux, one slave port to NumMstPorts master ports
// aw_sel_i must stay stable with aw_valid_i and be below NumMstPorts
// W bursts follow AW order, bursts are never interleaved

`timescale 1ns/100ps

module axi_wr_demux #(
  parameter int unsigned NumMstPorts = axi_wr_demux_pkg::DefNumMstPorts,
  parameter int unsigned MaxTrans    = axi_wr_demux_pkg::DefMaxTrans,
  parameter int unsigned LookBits    = axi_wr_demux_pkg::DefLookBits,
  localparam int unsigned SelWidth   = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  // slave AW
  input  logic                                          aw_valid_i,
  input  axi_wr_demux_pkg::aw_beat_t                    aw_beat_i,
  input  logic [SelWidth-1:0]                           aw_sel_i,
  output logic                                          aw_ready_o,
  // slave W
  input  logic                                          w_valid_i,
  input  axi_wr_demux_pkg::w_beat_t                     w_beat_i,
  output logic                                          w_ready_o,
  // slave B
  output logic                                          b_valid_o,
  output axi_wr_demux_pkg::b_beat_t                     b_beat_o,
  input  logic                                          b_ready_i,
  // master AW, beat is broadcast
  output logic [NumMstPorts-1:0]                        mst_aw_valid_o,
  output axi_wr_demux_pkg::aw_beat_t                    mst_aw_beat_o,
  input  logic [NumMstPorts-1:0]                        mst_aw_ready_i,
  // master W, beat is broadcast
  output logic [NumMstPorts-1:0]                        mst_w_valid_o,
  output axi_wr_demux_pkg::w_beat_t                     mst_w_beat_o,
  input  logic [NumMstPorts-1:0]                        mst_w_ready_i,
  // master B
  input  logic [NumMstPorts-1:0]                        mst_b_valid_i,
  input  axi_wr_demux_pkg::b_beat_t [NumMstPorts-1:0]   mst_b_beat_i,
  output logic [NumMstPorts-1:0]                        mst_b_ready_o
);

  // W queue handoff from the AW side
  logic                wq_push;
  logic [SelWidth-1:0] wq_sel;
  logic                wq_full;

  id_table_if #(
    .NumMstPorts ( NumMstPorts ),
    .LookBits    ( LookBits    )
  ) tbl_if ();

  // ------------------------------
  // AW admission and fan-out
  // ------------------------------
  aw_route_ctrl #(
    .NumMstPorts ( NumMstPorts ),
    .LookBits    ( LookBits    )
  ) u_aw_route_ctrl (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .aw_valid_i     ( aw_valid_i     ),
    .aw_beat_i      ( aw_beat_i      ),
    .aw_sel_i       ( aw_sel_i       ),
    .aw_ready_o     ( aw_ready_o     ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_beat_o  ( mst_aw_beat_o  ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .wq_full_i      ( wq_full        ),
    .wq_push_o      ( wq_push        ),
    .wq_sel_o       ( wq_sel         ),
    .tbl            ( tbl_if.ctrl    )
  );

  id_flight_table #(
    .NumMstPorts ( NumMstPorts ),
    .MaxTrans    ( MaxTrans    ),
    .LookBits    ( LookBits    )
  ) u_id_flight_table (
    .clk_i    ( clk_i           ),
    .arst_n_i ( arst_n_i        ),
    .tbl      ( tbl_if.tbl_side )
  );

  // ------------------------------
  // W steering and B merge
  // ------------------------------
  w_steer #(
    .NumMstPorts ( NumMstPorts ),
    .MaxTrans    ( MaxTrans    )
  ) u_w_steer (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .wq_push_i     ( wq_push       ),
    .wq_sel_i      ( wq_sel        ),
    .wq_full_o     ( wq_full       ),
    .w_valid_i     ( w_valid_i     ),
    .w_beat_i      ( w_beat_i      ),
    .w_ready_o     ( w_ready_o     ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_beat_o  ( mst_w_beat_o  ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  b_rr_arbiter #(
    .NumMstPorts ( NumMstPorts ),
    .LookBits    ( LookBits    )
  ) u_b_rr_arbiter (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_beat_i  ( mst_b_beat_i  ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .b_valid_o     ( b_valid_o     ),
    .b_beat_o      ( b_beat_o      ),
    .b_ready_i     ( b_ready_i     ),
    .tbl           ( tbl_if.retire )
  );

endmodule

// File: rtl/axi_wr_demux_pkg.sv
// shared widths, default sizes and beat structs for the write demux
// a burst carries len + 1 beats; no strobes and no user fields

package axi_wr_demux_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 16;
  localparam int unsigned LenWidth  = 4;

  // default sizes, overridden from the top level
  localparam int unsigned DefNumMstPorts = 3;
  localparam int unsigned DefMaxTrans    = 4;
  localparam int unsigned DefLookBits    = 2;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [LenWidth-1:0]  len_t;

  // ------------------------------
  // beat structs
  // ------------------------------
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_beat_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_beat_t;

  // resp is the usual two-bit response code
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_beat_t;

endpackage

// File: rtl/b_rr_arbiter.sv
// round-robin merge of master B responses onto the slave port
// a grant stays locked until b_ready_i, then the search restarts
// after the last served port

`timescale 1ns/100ps

module b_rr_arbiter #(
  parameter int unsigned NumMstPorts = axi_wr_demux_pkg::DefNumMstPorts,
  parameter int unsigned LookBits    = axi_wr_demux_pkg::DefLookBits
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic [NumMstPorts-1:0]                      mst_b_valid_i,
  input  axi_wr_demux_pkg::b_beat_t [NumMstPorts-1:0] mst_b_beat_i,
  output logic [NumMstPorts-1:0]                      mst_b_ready_o,
  output logic                                        b_valid_o,
  output axi_wr_demux_pkg::b_beat_t                   b_beat_o,
  input  logic                                        b_ready_i,
  id_table_if.retire                                  tbl
);

  localparam int unsigned SelWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1;

  logic [SelWidth-1:0] last_q;
  logic [SelWidth-1:0] lock_idx_q;
  logic                lock_q;
  logic [SelWidth-1:0] pick;
  logic                found;
  int                  idx;

  // ------------------------------
  // grant selection
  // ------------------------------
  always_comb begin
    found = 1'b0;
    pick  = last_q;
    idx   = 0;
    // search starts one past the last served port
    for (int k = 1; k <= int'(NumMstPorts); k++) begin
      idx = (int'(last_q) + k) % int'(NumMstPorts);
      if (!found && mst_b_valid_i[idx]) begin
        found = 1'b1;
        pick  = SelWidth'(idx);
      end
    end
    // a stalled response keeps its grant
    if (lock_q) begin
      pick = lock_idx_q;
    end
  end

  assign b_valid_o = mst_b_valid_i[pick];
  assign b_beat_o  = mst_b_beat_i[pick];

  always_comb begin
    mst_b_ready_o       = '0;
    mst_b_ready_o[pick] = b_ready_i & mst_b_valid_i[pick];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q     <= SelWidth'(NumMstPorts - 1);
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else if (b_valid_o && b_ready_i) begin
      last_q <= pick;
      lock_q <= 1'b0;
    end else if (b_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= pick;
    end
  end

  // each slave side handshake retires one outstanding write
  assign tbl.pop    = b_valid_o & b_ready_i;
  assign tbl.pop_id = b_beat_o.id[LookBits-1:0];

endmodule

// File: rtl/id_flight_table.sv
// outstanding write counters per low ID, each up to MaxTrans
// the stored select is only meaningful while its counter is nonzero

`timescale 1ns/100ps

module id_flight_table #(
  parameter int unsigned NumMstPorts = axi_wr_demux_pkg::DefNumMstPorts,
  parameter int unsigned MaxTrans    = axi_wr_demux_pkg::DefMaxTrans,
  parameter int unsigned LookBits    = axi_wr_demux_pkg::DefLookBits
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  id_table_if.tbl_side tbl
);

  localparam int unsigned SelWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1;
  localparam int unsigned NumIds   = 2 ** LookBits;
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);

  logic [CntWidth-1:0] cnt_q [NumIds];
  logic [SelWidth-1:0] sel_q [NumIds];
  logic [NumIds-1:0]   occupied;
  logic [NumIds-1:0]   cnt_full;

  // ------------------------------
  // one counter per tracked ID
  // ------------------------------
  for (genvar i = 0; i < NumIds; i++) begin : gen_cnt
    logic push_hit;
    logic pop_hit;

    assign push_hit = tbl.push && (tbl.push_id == LookBits'(i));
    assign pop_hit  = tbl.pop && (tbl.pop_id == LookBits'(i));

    // push and pop together cancel out
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q[i] <= '0;
      end else if (push_hit && !pop_hit) begin
        cnt_q[i] <= cnt_q[i] + CntWidth'(1);
      end else if (pop_hit && !push_hit) begin
        cnt_q[i] <= cnt_q[i] - CntWidth'(1);
      end
    end

    // port select loads on every push of this ID
    always_ff @(posedge clk_i) begin
      if (push_hit) begin
        sel_q[i] <= tbl.push_sel;
      end
    end

    assign occupied[i] = |cnt_q[i];
    assign cnt_full[i] = (cnt_q[i] == CntWidth'(MaxTrans));
  end

  assign tbl.lookup_sel = sel_q[tbl.lookup_id];
  assign tbl.occupied   = occupied[tbl.lookup_id];
  // any full counter stalls all AWs
  assign tbl.full       = |cnt_full;

endmodule

// File: rtl/id_table_if.sv
// lookup, push and pop lines of the in-flight ID table
// IDs here are already cut down to their low LookBits bits

`timescale 1ns/100ps

interface id_table_if #(
  parameter int unsigned NumMstPorts = axi_wr_demux_pkg::DefNumMstPorts,
  parameter int unsigned LookBits    = axi_wr_demux_pkg::DefLookBits
);

  localparam int unsigned SelWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1;

  // lookup of the AW currently offered
  logic [LookBits-1:0] lookup_id;
  logic [SelWidth-1:0] lookup_sel;
  logic                occupied;
  logic                full;
  // admission of an AW
  logic                push;
  logic [LookBits-1:0] push_id;
  logic [SelWidth-1:0] push_sel;
  // retirement on a slave side B handshake
  logic                pop;
  logic [LookBits-1:0] pop_id;

  modport ctrl (
    output lookup_id, push, push_id, push_sel,
    input  lookup_sel, occupied, full
  );

  // the table side, also takes the pops from the B arbiter
  modport tbl_side (
    input  lookup_id, push, push_id, push_sel, pop, pop_id,
    output lookup_sel, occupied, full
  );

  modport retire (
    output pop, pop_id
  );

endinterface

// File: rtl/w_steer.sv
// select queue of MaxTrans entries, W beats go to the head port
// not fall-through, a pushed select is usable one cycle later

`timescale 1ns/100ps

module w_steer #(
  parameter int unsigned NumMstPorts = axi_wr_demux_pkg::DefNumMstPorts,
  parameter int unsigned MaxTrans    = axi_wr_demux_pkg::DefMaxTrans,
  localparam int unsigned SelWidth   = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      wq_push_i,
  input  logic [SelWidth-1:0]       wq_sel_i,
  output logic                      wq_full_o,
  input  logic                      w_valid_i,
  input  axi_wr_demux_pkg::w_beat_t w_beat_i,
  output logic                      w_ready_o,
  output logic [NumMstPorts-1:0]    mst_w_valid_o,
  output axi_wr_demux_pkg::w_beat_t mst_w_beat_o,
  input  logic [NumMstPorts-1:0]    mst_w_ready_i
);

  localparam int unsigned PtrWidth = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);

  logic [SelWidth-1:0] mem [MaxTrans];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                empty;
  logic                pop;
  logic [SelWidth-1:0] head;

  assign empty     = (cnt_q == '0);
  assign wq_full_o = (cnt_q == CntWidth'(MaxTrans));
  assign head      = mem[rd_ptr_q];

  // ------------------------------
  // select queue
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (wq_push_i) begin
      mem[wr_ptr_q] <= wq_sel_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wq_push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(MaxTrans - 1)) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MaxTrans - 1)) ? '0 : rd_ptr_q + PtrWidth'(1);
      end
      // count moves only when push and pop differ
      if (wq_push_i && !pop) begin
        cnt_q <= cnt_q + CntWidth'(1);
      end else if (pop && !wq_push_i) begin
        cnt_q <= cnt_q - CntWidth'(1);
      end
    end
  end

  // beat steering, nothing passes while the queue is empty
  always_comb begin
    mst_w_valid_o = '0;
    w_ready_o     = 1'b0;
    for (int i = 0; i < int'(NumMstPorts); i++) begin
      if (!empty && (head == SelWidth'(i))) begin
        mst_w_valid_o[i] = w_valid_i;
        w_ready_o        = mst_w_ready_i[i];
      end
    end
  end

  // head retires with the last beat of its burst
  assign pop          = w_valid_i & w_ready_o & w_beat_i.last;
  assign mst_w_beat_o = w_beat_i;

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the write demux testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f axi_wr_demux.f --top-module tb_axi_wr_demux \
  -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 || {
  echo "build or simulation run failed, see build.log and sim.log"
  exit 1
}
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1 || exit 0

// File: tb/tb_axi_wr_demux.sv
// random bursts through the write demux, three master responders
// one process drives all inputs 1 ns after the rising edge
// handshakes are taken at the falling edge before

`timescale 1ns/100ps

module tb_axi_wr_demux;

  localparam int NumPorts = 3;
  localparam int NumBursts = 300;
  localparam int Timeout = 100000;
  localparam logic [15:0] Seed = 16'd25;

  logic clk_i;
  logic arst_n_i;
  logic aw_valid_i;
  axi_wr_demux_pkg::aw_beat_t aw_beat_i;
  logic [1:0] aw_sel_i;
  logic aw_ready_o;
  logic w_valid_i;
  axi_wr_demux_pkg::w_beat_t w_beat_i;
  logic w_ready_o;
  logic b_valid_o;
  axi_wr_demux_pkg::b_beat_t b_beat_o;
  logic b_ready_i;
  logic [NumPorts-1:0] mst_aw_valid_o;
  axi_wr_demux_pkg::aw_beat_t mst_aw_beat_o;
  logic [NumPorts-1:0] mst_aw_ready_i;
  logic [NumPorts-1:0] mst_w_valid_o;
  axi_wr_demux_pkg::w_beat_t mst_w_beat_o;
  logic [NumPorts-1:0] mst_w_ready_i;
  logic [NumPorts-1:0] mst_b_valid_i;
  axi_wr_demux_pkg::b_beat_t [NumPorts-1:0] mst_b_beat_i;
  logic [NumPorts-1:0] mst_b_ready_o;

  int chk_errs;
  int chk_b_cnt;
  int chk_pending;
  logic [15:0] lfsr_q;

  // burst list, drawn before the run
  axi_wr_demux_pkg::aw_beat_t bst_aw [NumBursts];
  logic [1:0] bst_sel [NumBursts];
  // responder state: accepted AW IDs, finished W bursts, queued B
  axi_wr_demux_pkg::id_t rsp_id [NumPorts][512];
  int rsp_id_wr [NumPorts];
  int rsp_id_rd [NumPorts];
  int w_done [NumPorts];
  axi_wr_demux_pkg::b_beat_t bq [NumPorts][512];
  int bq_wr [NumPorts];
  int bq_rd [NumPorts];

  axi_wr_demux #(
    .NumMstPorts ( NumPorts ),
    .MaxTrans    ( 4        ),
    .LookBits    ( 2        )
  ) dut (.*);

  wr_demux_checker #(
    .NumPorts ( NumPorts ),
    .MaxTrans ( 4        ),
    .LookBits ( 2        )
  ) chk (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .aw_valid_i     ( aw_valid_i     ),
    .aw_beat_i      ( aw_beat_i      ),
    .aw_sel_i       ( aw_sel_i       ),
    .aw_ready_i     ( aw_ready_o     ),
    .w_valid_i      ( w_valid_i      ),
    .w_beat_i       ( w_beat_i       ),
    .w_ready_i      ( w_ready_o      ),
    .b_valid_i      ( b_valid_o      ),
    .b_beat_i       ( b_beat_o       ),
    .b_ready_i      ( b_ready_i      ),
    .mst_aw_valid_i ( mst_aw_valid_o ),
    .mst_aw_beat_i  ( mst_aw_beat_o  ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .mst_w_valid_i  ( mst_w_valid_o  ),
    .mst_w_beat_i   ( mst_w_beat_o   ),
    .mst_w_ready_i  ( mst_w_ready_i  ),
    .mst_b_ready_i  ( mst_b_ready_o  ),
    .err_cnt_o      ( chk_errs       ),
    .b_cnt_o        ( chk_b_cnt      ),
    .pending_o      ( chk_pending    )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  initial begin : stimulus
    int cyc;
    int aw_idx;
    int w_idx;
    int w_cnt;
    int mb_seen;
    int other_errs;
    logic aw_fire;
    logic w_fire;
    logic [NumPorts-1:0] mb_fire;
    // every input at a known value from time zero
    arst_n_i = 1'b0;
    aw_valid_i = 1'b0;
    aw_beat_i = '0;
    aw_sel_i = '0;
    w_valid_i = 1'b0;
    w_beat_i = '0;
    b_ready_i = 1'b0;
    mst_aw_ready_i = '0;
    mst_w_ready_i = '0;
    mst_b_valid_i = '0;
    mst_b_beat_i = '0;
    lfsr_q = Seed;
    cyc = 0;
    aw_idx = 0;
    w_idx = 0;
    w_cnt = 0;
    mb_seen = 0;
    other_errs = 0;
    for (int p = 0; p < NumPorts; p++) begin
      rsp_id_wr[p] = 0;
      rsp_id_rd[p] = 0;
      w_done[p] = 0;
      bq_wr[p] = 0;
      bq_rd[p] = 0;
    end
    for (int i = 0; i < NumBursts; i++) begin
      bst_aw[i].id = axi_wr_demux_pkg::id_t'(rand_bits(4));
      bst_aw[i].addr = axi_wr_demux_pkg::addr_t'(rand_bits(16));
      bst_aw[i].len = axi_wr_demux_pkg::len_t'(rand_bits(3));
      bst_sel[i] = 2'(rand_bits(2) % NumPorts);
    end
    repeat (4) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    // ------------------------------
    // main loop until every master B is taken
    // ------------------------------
    while (mb_seen < NumBursts && cyc < Timeout) begin
      @(negedge clk_i);
      aw_fire = aw_valid_i & aw_ready_o;
      w_fire = w_valid_i & w_ready_o;
      mb_fire = mst_b_valid_i & mst_b_ready_o;
      for (int p = 0; p < NumPorts; p++) begin
        if (mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
          rsp_id[p][rsp_id_wr[p]] = mst_aw_beat_o.id;
          rsp_id_wr[p]++;
        end
        if (mst_w_valid_o[p] && mst_w_ready_i[p] && mst_w_beat_o.last)
          w_done[p]++;
      end
      @(posedge clk_i);
      #1;
      // slave AW source
      if (aw_fire) begin
        aw_valid_i = 1'b0;
        aw_idx++;
      end
      if (!aw_valid_i && aw_idx < NumBursts && rand_bits(1) == 1) begin
        aw_valid_i = 1'b1;
        aw_beat_i = bst_aw[aw_idx];
        aw_sel_i = bst_sel[aw_idx];
      end
      // slave W source, free to run ahead of its AW
      if (w_fire) begin
        w_valid_i = 1'b0;
        if (w_cnt == int'(bst_aw[w_idx].len)) begin
          w_idx++;
          w_cnt = 0;
        end else begin
          w_cnt++;
        end
      end
      if (!w_valid_i && w_idx < NumBursts && rand_bits(1) == 1) begin
        w_valid_i = 1'b1;
        w_beat_i.data = axi_wr_demux_pkg::data_t'(rand_bits(16));
        w_beat_i.last = (w_cnt == int'(bst_aw[w_idx].len));
      end
      b_ready_i = rand_bits(1) == 1;
      // master responders, B carries the AW ID and the port number
      for (int p = 0; p < NumPorts; p++) begin
        mst_aw_ready_i[p] = rand_bits(1) == 1;
        mst_w_ready_i[p] = rand_bits(1) == 1;
        while (w_done[p] > 0 && rsp_id_rd[p] < rsp_id_wr[p]) begin
          bq[p][bq_wr[p]].id = rsp_id[p][rsp_id_rd[p]];
          bq[p][bq_wr[p]].resp = 2'(p);
          bq_wr[p]++;
          rsp_id_rd[p]++;
          w_done[p]--;
        end
        if (mb_fire[p]) begin
          mst_b_valid_i[p] = 1'b0;
          bq_rd[p]++;
          mb_seen++;
        end
        if (!mst_b_valid_i[p] && bq_rd[p] < bq_wr[p] && rand_bits(1) == 1) begin
          mst_b_valid_i[p] = 1'b1;
          mst_b_beat_i[p] = bq[p][bq_rd[p]];
        end
      end
      cyc++;
    end

    if (mb_seen < NumBursts) begin
      $display("timeout: %0d of %0d B responses taken from the masters after %0d cycles",
               mb_seen, NumBursts, cyc);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      if (chk_b_cnt != NumBursts) begin
        $display("FAIL %0t: slave side saw %0d B responses instead of %0d",
                 $time, chk_b_cnt, NumBursts);
        other_errs++;
      end
      if (chk_pending != 0) begin
        $display("FAIL %0t: %0d AW or W items left unmatched at the end",
                 $time, chk_pending);
        other_errs++;
      end
      $display("errors: %0d checker, %0d end of run; B responses %0d of %0d",
               chk_errs, other_errs, chk_b_cnt, NumBursts);
      if (chk_errs == 0 && other_errs == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

// File: tb/wr_demux_checker.sv
// watches the demux ports at the falling edge, where all values are settled
// a flagged handshake there transfers on the next rising edge
// sized for at most 512 AWs per port over one run

`timescale 1ns/100ps

module wr_demux_checker #(
  parameter int NumPorts = 3,
  parameter int MaxTrans = 4,
  parameter int LookBits = 2
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     aw_valid_i,
  input  axi_wr_demux_pkg::aw_beat_t               aw_beat_i,
  input  logic [1:0]                               aw_sel_i,
  input  logic                                     aw_ready_i,
  input  logic                                     w_valid_i,
  input  axi_wr_demux_pkg::w_beat_t                w_beat_i,
  input  logic                                     w_ready_i,
  input  logic                                     b_valid_i,
  input  axi_wr_demux_pkg::b_beat_t                b_beat_i,
  input  logic                                     b_ready_i,
  input  logic [NumPorts-1:0]                      mst_aw_valid_i,
  input  axi_wr_demux_pkg::aw_beat_t               mst_aw_beat_i,
  input  logic [NumPorts-1:0]                      mst_aw_ready_i,
  input  logic [NumPorts-1:0]                      mst_w_valid_i,
  input  axi_wr_demux_pkg::w_beat_t                mst_w_beat_i,
  input  logic [NumPorts-1:0]                      mst_w_ready_i,
  input  logic [NumPorts-1:0]                      mst_b_ready_i,
  output int                                       err_cnt_o,
  output int                                       b_cnt_o,
  output int                                       pending_o
);

  // expected AWs per port, in slave order
  axi_wr_demux_pkg::aw_beat_t exp_aw [NumPorts][512];
  int exp_wr [NumPorts];
  int exp_rd [NumPorts];
  // burst order from the slave AW side, and W beats seen on the masters
  int wo_sel [$];
  int wo_len [$];
  int obs_port [$];
  logic obs_last [$];
  int beat_idx;
  // outstanding model per low ID
  int out_cnt [2**LookBits];
  int out_port [2**LookBits];
  // held valids for the back-pressure rule
  logic [NumPorts-1:0] aw_hold;
  logic [NumPorts-1:0] w_hold;
  logic b_hold;
  axi_wr_demux_pkg::aw_beat_t aw_hold_beat;
  axi_wr_demux_pkg::w_beat_t w_hold_beat;
  axi_wr_demux_pkg::b_beat_t b_hold_beat;

  initial begin
    err_cnt_o = 0;
    b_cnt_o = 0;
    pending_o = 0;
    beat_idx = 0;
    aw_hold = '0;
    w_hold = '0;
    b_hold = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      exp_wr[p] = 0;
      exp_rd[p] = 0;
    end
    for (int i = 0; i < 2**LookBits; i++) begin
      out_cnt[i] = 0;
      out_port[i] = 0;
    end
  end

  task automatic flag_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  // pairs W beats seen on the masters with the burst order of the AWs
  task automatic match_w_beats();
    while (wo_sel.size() > 0 && obs_port.size() > 0) begin
      if (obs_port[0] != wo_sel[0])
        flag_error($sformatf("W beat on port %0d, burst belongs to port %0d",
                             obs_port[0], wo_sel[0]));
      if (obs_last[0] != (beat_idx == wo_len[0]))
        flag_error($sformatf("W last flag %0b on beat %0d of len %0d",
                             obs_last[0], beat_idx, wo_len[0]));
      if (beat_idx == wo_len[0]) begin
        void'(wo_sel.pop_front());
        void'(wo_len.pop_front());
        beat_idx = 0;
      end else begin
        beat_idx++;
      end
      void'(obs_port.pop_front());
      void'(obs_last.pop_front());
    end
  endtask

  always @(negedge clk_i) begin : watch
    int lid;
    int s_fire;
    int m_fire;
    if (!arst_n_i) begin
      if (aw_ready_i || w_ready_i || b_valid_i || (|mst_aw_valid_i) ||
          (|mst_w_valid_i) || (|mst_b_ready_i))
        flag_error("control output high during reset");
    end else begin
      // ------------------------------
      // back-pressure
      // ------------------------------
      for (int p = 0; p < NumPorts; p++) begin
        if (aw_hold[p] && (!mst_aw_valid_i[p] || mst_aw_beat_i != aw_hold_beat))
          flag_error($sformatf("AW on port %0d dropped or changed while stalled", p));
        if (w_hold[p] && (!mst_w_valid_i[p] || mst_w_beat_i != w_hold_beat))
          flag_error($sformatf("W on port %0d dropped or changed while stalled", p));
      end
      if (b_hold && (!b_valid_i || b_beat_i != b_hold_beat))
        flag_error("slave B dropped or changed while stalled");

      // ------------------------------
      // AW routing and ordering
      // ------------------------------
      if (aw_valid_i && aw_ready_i) begin
        exp_aw[aw_sel_i][exp_wr[aw_sel_i]] = aw_beat_i;
        exp_wr[aw_sel_i]++;
        wo_sel.push_back(int'(aw_sel_i));
        wo_len.push_back(int'(aw_beat_i.len));
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (mst_aw_valid_i[p] && mst_aw_ready_i[p]) begin
          lid = int'(mst_aw_beat_i.id) % (2**LookBits);
          if (exp_rd[p] == exp_wr[p]) begin
            flag_error($sformatf("unexpected AW on port %0d", p));
          end else begin
            if (mst_aw_beat_i != exp_aw[p][exp_rd[p]])
              flag_error($sformatf("AW on port %0d is %h, expected %h", p,
                                   mst_aw_beat_i, exp_aw[p][exp_rd[p]]));
            exp_rd[p]++;
          end
          if (out_cnt[lid] != 0 && out_port[lid] != p)
            flag_error($sformatf("ID %0d sent to port %0d, outstanding at port %0d",
                                 lid, p, out_port[lid]));
          out_cnt[lid]++;
          out_port[lid] = p;
          if (out_cnt[lid] > MaxTrans)
            flag_error($sformatf("ID %0d has %0d outstanding", lid, out_cnt[lid]));
        end
      end

      // ------------------------------
      // W steering
      // ------------------------------
      s_fire = (w_valid_i && w_ready_i) ? 1 : 0;
      m_fire = 0;
      for (int p = 0; p < NumPorts; p++) begin
        if (mst_w_valid_i[p] && mst_w_ready_i[p]) begin
          m_fire++;
          if (mst_w_beat_i != w_beat_i)
            flag_error($sformatf("W beat on port %0d differs from slave beat", p));
          obs_port.push_back(p);
          obs_last.push_back(mst_w_beat_i.last);
        end
      end
      if (m_fire != s_fire)
        flag_error($sformatf("%0d master W transfers for %0d slave", m_fire, s_fire));
      match_w_beats();

      // B retires after the AW check, matching the table update
      if (b_valid_i && b_ready_i) begin
        b_cnt_o++;
        lid = int'(b_beat_i.id) % (2**LookBits);
        if (out_cnt[lid] == 0) begin
          flag_error($sformatf("B with ID %h not outstanding", b_beat_i.id));
        end else begin
          if (int'(b_beat_i.resp) != out_port[lid])
            flag_error($sformatf("B resp %0d, served by port %0d", b_beat_i.resp,
                                 out_port[lid]));
          out_cnt[lid]--;
        end
      end

      aw_hold = mst_aw_valid_i & ~mst_aw_ready_i;
      w_hold = mst_w_valid_i & ~mst_w_ready_i;
      b_hold = b_valid_i & ~b_ready_i;
      aw_hold_beat = mst_aw_beat_i;
      w_hold_beat = mst_w_beat_i;
      b_hold_beat = b_beat_i;
    end
    pending_o = wo_sel.size() + obs_port.size();
    for (int p = 0; p < NumPorts; p++)
      pending_o += exp_wr[p] - exp_rd[p];
  end

endmodule
